// ==== project.f ====
+incdir+include
src/rv32i_decoder_pkg.sv
src/branch_jump_decoder.sv
src/load_store_decoder.sv
src/alu_decoder.sv
src/system_decoder.sv
src/rv32i_decoder.sv
verification/tb_rv32i_decoder.sv

// ==== run.sh ====
#!/bin/sh
# Build the decoder testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --top-module tb_rv32i_decoder -f project.f -Mdir build/obj_dir
./build/obj_dir/Vtb_rv32i_decoder | tee build/sim.log

if grep -q "RESULT: FAIL" build/sim.log; then
        echo "Simulation failed, see build/sim.log"
        exit 1
fi
echo "Simulation passed"

// ==== src/alu_decoder.sv ====
// Group decoder for LUI, AUIPC and the register-immediate and register-register ALU ops
`timescale 1ns/1ps

module alu_decoder import rv32i_decoder_pkg::*; (
        input  rv32_instr_t   instr_i,
        output decoder_ctrl_t ctrl_o,
        output logic          hit_o
);

        always_comb begin
                ctrl_o        = DECODER_CTRL_NONE;
                hit_o         = 1'b1;
                ctrl_o.alu_en = 1'b1; // Cleared below when not an ALU opcode
                ctrl_o.rf_we  = 1'b1; // Every op here writes rd
                case (instr_i.opcode)
                OPCODE_LUI: begin
                        // U immediate plus zero
                        ctrl_o.alu_op_a_mux_sel = OP_A_IMM;
                        ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
                        ctrl_o.imm_a_mux_sel    = IMMA_ZERO;
                        ctrl_o.imm_b_mux_sel    = IMMB_U;
                end
                OPCODE_AUIPC: begin
                        ctrl_o.alu_op_a_mux_sel = OP_A_CURRPC;
                        ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
                        ctrl_o.imm_b_mux_sel    = IMMB_U;
                end
                OPCODE_OPIMM: begin
                        ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                        ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
                        ctrl_o.imm_b_mux_sel    = IMMB_I;
                        ctrl_o.rf_re[0]         = 1'b1;
                        case (instr_i.funct3)
                        3'b000: ctrl_o.alu_operator = ALU_ADD;
                        3'b010: ctrl_o.alu_operator = ALU_SLT;
                        3'b011: ctrl_o.alu_operator = ALU_SLTU;
                        3'b100: ctrl_o.alu_operator = ALU_XOR;
                        3'b110: ctrl_o.alu_operator = ALU_OR;
                        3'b111: ctrl_o.alu_operator = ALU_AND;
                        3'b001: begin
                                ctrl_o.alu_operator = ALU_SLL;
                                if (instr_i.funct7 != FUNCT7_ZERO)
                                        ctrl_o = DECODER_CTRL_ILLEGAL;
                        end
                        default: begin // Right shifts
                                if (instr_i.funct7 == FUNCT7_ZERO)
                                        ctrl_o.alu_operator = ALU_SRL;
                                else if (instr_i.funct7 == FUNCT7_ALT)
                                        ctrl_o.alu_operator = ALU_SRA;
                                else
                                        ctrl_o = DECODER_CTRL_ILLEGAL;
                        end
                        endcase
                end
                OPCODE_OP: begin
                        ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                        ctrl_o.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
                        ctrl_o.rf_re            = 2'b11;
                        case ({instr_i.funct7, instr_i.funct3})
                        {FUNCT7_ZERO, 3'b000}: ctrl_o.alu_operator = ALU_ADD;
                        {FUNCT7_ALT,  3'b000}: ctrl_o.alu_operator = ALU_SUB;
                        {FUNCT7_ZERO, 3'b001}: ctrl_o.alu_operator = ALU_SLL;
                        {FUNCT7_ZERO, 3'b010}: ctrl_o.alu_operator = ALU_SLT;
                        {FUNCT7_ZERO, 3'b011}: ctrl_o.alu_operator = ALU_SLTU;
                        {FUNCT7_ZERO, 3'b100}: ctrl_o.alu_operator = ALU_XOR;
                        {FUNCT7_ZERO, 3'b101}: ctrl_o.alu_operator = ALU_SRL;
                        {FUNCT7_ALT,  3'b101}: ctrl_o.alu_operator = ALU_SRA;
                        {FUNCT7_ZERO, 3'b110}: ctrl_o.alu_operator = ALU_OR;
                        {FUNCT7_ZERO, 3'b111}: ctrl_o.alu_operator = ALU_AND;
                        default:               ctrl_o = DECODER_CTRL_ILLEGAL; // M ext and reserved
                        endcase
                end
                default: begin
                        ctrl_o = DECODER_CTRL_NONE;
                        hit_o  = 1'b0;
                end
                endcase
        end

endmodule

// ==== src/branch_jump_decoder.sv ====
// Group decoder for JAL, JALR and the conditional branches
`timescale 1ns/1ps

module branch_jump_decoder import rv32i_decoder_pkg::*; (
        input  rv32_instr_t   instr_i,
        output decoder_ctrl_t ctrl_o,
        output logic          hit_o
);

        always_comb begin
                ctrl_o = DECODER_CTRL_NONE;
                hit_o  = 1'b1;
                case (instr_i.opcode)
                OPCODE_JAL, OPCODE_JALR: begin
                        // Link address is PC plus the increment
                        ctrl_o.alu_en           = 1'b1;
                        ctrl_o.alu_jmp          = 1'b1;
                        ctrl_o.alu_op_a_mux_sel = OP_A_CURRPC;
                        ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
                        ctrl_o.imm_b_mux_sel    = IMMB_PCINCR;
                        ctrl_o.alu_operator     = ALU_ADD;
                        ctrl_o.rf_we            = 1'b1;        // Write link register
                        ctrl_o.ctrl_xfer        = CT_JAL;
                        if (instr_i.opcode == OPCODE_JALR) begin
                                ctrl_o.alu_jmpr  = 1'b1;       // Target from rs1, hazard check
                                ctrl_o.rf_re[0]  = 1'b1;
                                ctrl_o.ctrl_xfer = CT_JALR;
                                if (instr_i.funct3 != 3'b000)
                                        ctrl_o = DECODER_CTRL_ILLEGAL;
                        end
                end
                OPCODE_BRANCH: begin
                        ctrl_o.alu_en           = 1'b1;
                        ctrl_o.alu_bch          = 1'b1;
                        ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                        ctrl_o.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
                        ctrl_o.op_c_mux_sel     = OP_C_BCH;    // Branch target path
                        ctrl_o.rf_re            = 2'b11;
                        ctrl_o.ctrl_xfer        = CT_BCH;
                        case (instr_i.funct3)
                        3'b000:  ctrl_o.alu_operator = ALU_EQ;
                        3'b001:  ctrl_o.alu_operator = ALU_NE;
                        3'b100:  ctrl_o.alu_operator = ALU_LT;
                        3'b101:  ctrl_o.alu_operator = ALU_GE;
                        3'b110:  ctrl_o.alu_operator = ALU_LTU;
                        3'b111:  ctrl_o.alu_operator = ALU_GEU;
                        default: ctrl_o = DECODER_CTRL_ILLEGAL; // funct3 2 and 3
                        endcase
                end
                default: hit_o = 1'b0; // Not a control transfer
                endcase
        end

endmodule

// ==== src/load_store_decoder.sv ====
// Group decoder for loads and stores with access width and sign extension
`timescale 1ns/1ps

module load_store_decoder import rv32i_decoder_pkg::*; (
        input  rv32_instr_t   instr_i,
        output decoder_ctrl_t ctrl_o,
        output logic          hit_o
);

        always_comb begin
                ctrl_o = DECODER_CTRL_NONE;
                hit_o  = 1'b1;
                case (instr_i.opcode)
                OPCODE_LOAD: begin
                        ctrl_o.lsu_en           = 1'b1;
                        ctrl_o.rf_we            = 1'b1;
                        ctrl_o.rf_re[0]         = 1'b1;             // Base address
                        ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                        ctrl_o.alu_op_b_mux_sel = OP_B_IMM;         // Offset
                        ctrl_o.imm_b_mux_sel    = IMMB_I;
                        ctrl_o.lsu_sign_ext     = ~instr_i.funct3[2]; // LBU and LHU zero extend
                        ctrl_o.lsu_type         = instr_i.funct3[1:0];
                        // Reserved widths and the RV64 LD
                        if (instr_i.funct3 == 3'b011 || instr_i.funct3[2:1] == 2'b11)
                                ctrl_o = DECODER_CTRL_ILLEGAL;
                end
                OPCODE_STORE: begin
                        ctrl_o.lsu_en           = 1'b1;
                        ctrl_o.lsu_we           = 1'b1;
                        ctrl_o.rf_re            = 2'b11;
                        ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                        ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
                        ctrl_o.op_c_mux_sel     = OP_C_REGB_OR_FWD; // Store data
                        ctrl_o.imm_b_mux_sel    = IMMB_S;
                        ctrl_o.lsu_type         = instr_i.funct3[1:0];
                        if (instr_i.funct3 >= 3'b011)
                                ctrl_o = DECODER_CTRL_ILLEGAL; // Only SB, SH, SW
                end
                default: hit_o = 1'b0;
                endcase
        end

endmodule

// ==== src/rv32i_decoder.sv ====
// Top of the RV32I decoder merging the four opcode-group decoders
`timescale 1ns/1ps

module rv32i_decoder import rv32i_decoder_pkg::*; (
        input  rv32_instr_t   instr_i,
        input  ctrl_fsm_t     ctrl_fsm_i,
        output decoder_ctrl_t decoder_ctrl_o
);

        decoder_ctrl_t bj_ctrl, ls_ctrl, alu_ctrl, sys_ctrl; // Idle unless their group hits
        logic          bj_hit,  ls_hit,  alu_hit,  sys_hit;

        branch_jump_decoder branch_jump_decoder_i (
                .instr_i (instr_i),
                .ctrl_o  (bj_ctrl),
                .hit_o   (bj_hit)
        );

        load_store_decoder load_store_decoder_i (
                .instr_i (instr_i),
                .ctrl_o  (ls_ctrl),
                .hit_o   (ls_hit)
        );

        alu_decoder alu_decoder_i (
                .instr_i (instr_i),
                .ctrl_o  (alu_ctrl),
                .hit_o   (alu_hit)
        );

        system_decoder system_decoder_i (
                .instr_i    (instr_i),
                .ctrl_fsm_i (ctrl_fsm_i),
                .ctrl_o     (sys_ctrl),
                .hit_o      (sys_hit)
        );

        // At most one group hits, so OR is a plain merge
        always_comb begin
                decoder_ctrl_o = decoder_ctrl_t'(bj_ctrl | ls_ctrl | alu_ctrl | sys_ctrl);
                if (!(bj_hit || ls_hit || alu_hit || sys_hit))
                        decoder_ctrl_o.illegal_insn = 1'b1; // Unknown opcode
        end

endmodule

// ==== src/rv32i_decoder_pkg.sv ====
// Opcodes, instruction layout, control enums, control bundle and its constant values
package rv32i_decoder_pkg;

        //////////////////////////////
        // Major opcodes
        //////////////////////////////

        localparam logic [6:0] OPCODE_JAL    = 7'h6f;
        localparam logic [6:0] OPCODE_JALR   = 7'h67;
        localparam logic [6:0] OPCODE_BRANCH = 7'h63;
        localparam logic [6:0] OPCODE_LOAD   = 7'h03;
        localparam logic [6:0] OPCODE_STORE  = 7'h23;
        localparam logic [6:0] OPCODE_LUI    = 7'h37;
        localparam logic [6:0] OPCODE_AUIPC  = 7'h17;
        localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
        localparam logic [6:0] OPCODE_OP     = 7'h33;
        localparam logic [6:0] OPCODE_FENCE  = 7'h0f; // FENCE and FENCE.I
        localparam logic [6:0] OPCODE_SYSTEM = 7'h73; // Privileged and CSR

        localparam logic [6:0] FUNCT7_ZERO = 7'h00;
        localparam logic [6:0] FUNCT7_ALT  = 7'h20; // Bit 30 picks SUB and SRA

        // funct12 of the privileged instructions
        localparam logic [11:0] SYS_ECALL  = 12'h000;
        localparam logic [11:0] SYS_EBREAK = 12'h001;
        localparam logic [11:0] SYS_MRET   = 12'h302;
        localparam logic [11:0] SYS_DRET   = 12'h7b2; // Debug mode only
        localparam logic [11:0] SYS_WFI    = 12'h105;

        // R-type view, the other formats reuse these bit positions
        typedef struct packed {
                logic [6:0] funct7;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] rd;
                logic [6:0] opcode;
        } rv32_instr_t;

        //////////////////////////////
        // Control encodings
        //////////////////////////////

        // Zero code of every enum is the idle value
        typedef enum logic [3:0] {
                ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
                ALU_SRL, ALU_SRA, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
        } alu_op_e;

        typedef enum logic [1:0] {OP_A_NONE, OP_A_REGA_OR_FWD, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
        typedef enum logic [1:0] {OP_B_NONE, OP_B_REGB_OR_FWD, OP_B_IMM} op_b_sel_e;
        typedef enum logic [1:0] {OP_C_NONE, OP_C_REGB_OR_FWD, OP_C_BCH} op_c_sel_e;
        typedef enum logic {IMMA_ZERO, IMMA_Z} imm_a_sel_e; // Z is the CSR uimm in rs1
        typedef enum logic [2:0] {IMMB_NONE, IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
        typedef enum logic [1:0] {CT_NONE, CT_JAL, CT_JALR, CT_BCH} ctrl_xfer_e;
        typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

        // Controller status seen by the decoder
        typedef struct packed {
                logic debug_mode;
                logic debug_wfi_no_sleep; // Keep WFI from sleeping while stepping
        } ctrl_fsm_t;

        //////////////////////////////
        // Control bundle
        //////////////////////////////

        typedef struct packed {
                logic       alu_en;
                logic       alu_bch;
                logic       alu_jmp;
                logic       alu_jmpr;      // Jump target from rs1
                logic       lsu_en;
                logic       lsu_we;
                logic       lsu_sign_ext;
                logic       sys_en;
                logic       csr_en;
                logic [1:0] lsu_type;      // Byte, half, word
                op_a_sel_e  alu_op_a_mux_sel;
                op_b_sel_e  alu_op_b_mux_sel;
                op_c_sel_e  op_c_mux_sel;
                imm_a_sel_e imm_a_mux_sel;
                imm_b_sel_e imm_b_mux_sel;
                alu_op_e    alu_operator;
                csr_op_e    csr_op;
                ctrl_xfer_e ctrl_xfer;
                logic       rf_we;
                logic [1:0] rf_re;         // Bit 0 rs1, bit 1 rs2
                logic       sys_fencei_insn;
                logic       sys_ecall_insn;
                logic       sys_ebrk_insn;
                logic       sys_mret_insn;
                logic       sys_dret_insn;
                logic       sys_wfi_insn;
                logic       illegal_insn;  // Bit 0 of the bundle
        } decoder_ctrl_t;

        localparam decoder_ctrl_t DECODER_CTRL_NONE    = decoder_ctrl_t'(0);
        localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = decoder_ctrl_t'(1); // Only illegal_insn

endpackage

// ==== src/system_decoder.sv ====
// Group decoder for FENCE, the privileged SYSTEM instructions and CSR accesses
`timescale 1ns/1ps

module system_decoder import rv32i_decoder_pkg::*; (
        input  rv32_instr_t   instr_i,
        input  ctrl_fsm_t     ctrl_fsm_i,
        output decoder_ctrl_t ctrl_o,
        output logic          hit_o
);

        logic [11:0] funct12; // Privileged instruction code

        assign funct12 = {instr_i.funct7, instr_i.rs2};

        always_comb begin
                ctrl_o = DECODER_CTRL_NONE;
                hit_o  = 1'b1;
                case (instr_i.opcode)
                OPCODE_FENCE: begin
                        // FENCE handled as the stronger FENCE.I, both flush the pipeline
                        ctrl_o.sys_en          = 1'b1;
                        ctrl_o.sys_fencei_insn = 1'b1;
                        if (instr_i.funct3[2:1] != 2'b00)
                                ctrl_o = DECODER_CTRL_ILLEGAL;
                end
                OPCODE_SYSTEM: begin
                        if (instr_i.funct3 == 3'b000) begin
                                ctrl_o.sys_en = 1'b1;
                                case (funct12)
                                SYS_ECALL:  ctrl_o.sys_ecall_insn = 1'b1;
                                SYS_EBREAK: ctrl_o.sys_ebrk_insn  = 1'b1;
                                SYS_MRET:   ctrl_o.sys_mret_insn  = 1'b1;
                                SYS_DRET: begin
                                        if (ctrl_fsm_i.debug_mode)
                                                ctrl_o.sys_dret_insn = 1'b1;
                                        else
                                                ctrl_o = DECODER_CTRL_ILLEGAL;
                                end
                                // No sleep while single stepping
                                SYS_WFI:    ctrl_o.sys_wfi_insn = ~ctrl_fsm_i.debug_wfi_no_sleep;
                                default:    ctrl_o = DECODER_CTRL_ILLEGAL;
                                endcase
                                if (instr_i.rs1 != 5'd0 || instr_i.rd != 5'd0)
                                        ctrl_o = DECODER_CTRL_ILLEGAL;
                        end else begin
                                // CSR access, address in the I immediate
                                ctrl_o.csr_en           = 1'b1;
                                ctrl_o.rf_we            = 1'b1;
                                ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
                                ctrl_o.imm_a_mux_sel    = IMMA_Z;
                                ctrl_o.imm_b_mux_sel    = IMMB_I;
                                if (instr_i.funct3[2]) begin
                                        ctrl_o.alu_op_a_mux_sel = OP_A_IMM; // rs1 field is uimm
                                end else begin
                                        ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                                        ctrl_o.rf_re[0]         = 1'b1;
                                end
                                // Set or clear with x0 or zero uimm writes nothing
                                case (instr_i.funct3[1:0])
                                2'b01: ctrl_o.csr_op = CSR_OP_WRITE;
                                2'b10: ctrl_o.csr_op = (instr_i.rs1 == 5'd0) ? CSR_OP_READ : CSR_OP_SET;
                                2'b11: ctrl_o.csr_op = (instr_i.rs1 == 5'd0) ? CSR_OP_READ : CSR_OP_CLEAR;
                                default: ctrl_o = DECODER_CTRL_ILLEGAL;
                                endcase
                        end
                end
                default: hit_o = 1'b0;
                endcase
        end

endmodule

// ==== include/decoder_ref_model.svh ====
// Reference model of the RV32I decoder, expected control bundle per instruction
`ifndef DECODER_REF_MODEL_SVH
`define DECODER_REF_MODEL_SVH

function automatic decoder_ctrl_t expected_ctrl(input rv32_instr_t ins, input ctrl_fsm_t fsm);
        decoder_ctrl_t e;
        logic          bad;  // Reserved encoding seen
        logic [11:0]   f12;
        logic          alt;  // funct7 with bit 30 set
        e   = DECODER_CTRL_NONE;
        bad = 1'b0;
        f12 = {ins.funct7, ins.rs2};
        alt = ins.funct7 == FUNCT7_ALT;
        case (ins.opcode)
        OPCODE_JAL, OPCODE_JALR: begin
                e.alu_en           = 1'b1;
                e.alu_jmp          = 1'b1;
                e.alu_jmpr         = ins.opcode == OPCODE_JALR;
                e.alu_op_a_mux_sel = OP_A_CURRPC;       // Link = PC + increment
                e.alu_op_b_mux_sel = OP_B_IMM;
                e.imm_b_mux_sel    = IMMB_PCINCR;
                e.rf_we            = 1'b1;
                e.rf_re            = {1'b0, ins.opcode == OPCODE_JALR};
                e.ctrl_xfer        = (ins.opcode == OPCODE_JALR) ? CT_JALR : CT_JAL;
                bad                = ins.opcode == OPCODE_JALR && ins.funct3 != 3'd0;
        end
        OPCODE_BRANCH: begin
                e.alu_en           = 1'b1;
                e.alu_bch          = 1'b1;
                e.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                e.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
                e.op_c_mux_sel     = OP_C_BCH;
                e.rf_re            = 2'b11;
                e.ctrl_xfer        = CT_BCH;
                case (ins.funct3)
                3'd0:    e.alu_operator = ALU_EQ;
                3'd1:    e.alu_operator = ALU_NE;
                3'd4:    e.alu_operator = ALU_LT;
                3'd5:    e.alu_operator = ALU_GE;
                3'd6:    e.alu_operator = ALU_LTU;
                3'd7:    e.alu_operator = ALU_GEU;
                default: bad = 1'b1;
                endcase
        end
        OPCODE_LOAD, OPCODE_STORE: begin
                e.lsu_en           = 1'b1;
                e.lsu_type         = ins.funct3[1:0];
                e.alu_op_a_mux_sel = OP_A_REGA_OR_FWD; // Address = rs1 + offset
                e.alu_op_b_mux_sel = OP_B_IMM;
                e.rf_re[0]         = 1'b1;
                if (ins.opcode == OPCODE_LOAD) begin
                        e.rf_we         = 1'b1;
                        e.lsu_sign_ext  = ~ins.funct3[2];
                        e.imm_b_mux_sel = IMMB_I;
                        bad             = ins.funct3 inside {3'd3, 3'd6, 3'd7};
                end else begin
                        e.lsu_we        = 1'b1;
                        e.rf_re[1]      = 1'b1;
                        e.op_c_mux_sel  = OP_C_REGB_OR_FWD; // Store data
                        e.imm_b_mux_sel = IMMB_S;
                        bad             = ins.funct3 >= 3'd3;
                end
        end
        OPCODE_LUI, OPCODE_AUIPC: begin
                e.alu_en           = 1'b1;
                e.rf_we            = 1'b1;
                e.alu_op_a_mux_sel = (ins.opcode == OPCODE_LUI) ? OP_A_IMM : OP_A_CURRPC;
                e.alu_op_b_mux_sel = OP_B_IMM;
                e.imm_b_mux_sel    = IMMB_U;
        end
        OPCODE_OPIMM, OPCODE_OP: begin
                e.alu_en           = 1'b1;
                e.rf_we            = 1'b1;
                e.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
                e.rf_re[0]         = 1'b1;
                if (ins.opcode == OPCODE_OP) begin
                        e.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
                        e.rf_re[1]         = 1'b1;
                        bad = !(ins.funct7 == FUNCT7_ZERO || (alt && ins.funct3 inside {3'd0, 3'd5}));
                end else begin
                        e.alu_op_b_mux_sel = OP_B_IMM;
                        e.imm_b_mux_sel    = IMMB_I;
                        // Shift amount field leaves funct7 for the shift kind
                        bad = (ins.funct3 == 3'd1 && ins.funct7 != FUNCT7_ZERO) ||
                              (ins.funct3 == 3'd5 && ins.funct7 != FUNCT7_ZERO && !alt);
                end
                case (ins.funct3)
                3'd0:    e.alu_operator = (alt && ins.opcode == OPCODE_OP) ? ALU_SUB : ALU_ADD;
                3'd1:    e.alu_operator = ALU_SLL;
                3'd2:    e.alu_operator = ALU_SLT;
                3'd3:    e.alu_operator = ALU_SLTU;
                3'd4:    e.alu_operator = ALU_XOR;
                3'd5:    e.alu_operator = alt ? ALU_SRA : ALU_SRL;
                3'd6:    e.alu_operator = ALU_OR;
                default: e.alu_operator = ALU_AND;
                endcase
        end
        OPCODE_FENCE: begin
                e.sys_en          = 1'b1;
                e.sys_fencei_insn = 1'b1;
                bad               = ins.funct3 > 3'd1;
        end
        OPCODE_SYSTEM: begin
                if (ins.funct3 == 3'd0) begin
                        e.sys_en         = 1'b1;
                        e.sys_ecall_insn = f12 == SYS_ECALL;
                        e.sys_ebrk_insn  = f12 == SYS_EBREAK;
                        e.sys_mret_insn  = f12 == SYS_MRET;
                        e.sys_dret_insn  = f12 == SYS_DRET;
                        e.sys_wfi_insn   = f12 == SYS_WFI && !fsm.debug_wfi_no_sleep;
                        bad = !(f12 inside {SYS_ECALL, SYS_EBREAK, SYS_MRET, SYS_DRET, SYS_WFI}) ||
                              (f12 == SYS_DRET && !fsm.debug_mode) ||
                              ins.rs1 != 5'd0 || ins.rd != 5'd0;
                end else begin
                        e.csr_en           = 1'b1;
                        e.rf_we            = 1'b1;
                        e.alu_op_b_mux_sel = OP_B_IMM;
                        e.imm_a_mux_sel    = IMMA_Z;
                        e.imm_b_mux_sel    = IMMB_I;
                        e.alu_op_a_mux_sel = ins.funct3[2] ? OP_A_IMM : OP_A_REGA_OR_FWD;
                        e.rf_re[0]         = ~ins.funct3[2];
                        case (ins.funct3[1:0])
                        2'd1:    e.csr_op = CSR_OP_WRITE;
                        2'd2:    e.csr_op = (ins.rs1 == 5'd0) ? CSR_OP_READ : CSR_OP_SET;
                        2'd3:    e.csr_op = (ins.rs1 == 5'd0) ? CSR_OP_READ : CSR_OP_CLEAR;
                        default: bad = 1'b1;
                        endcase
                end
        end
        default: bad = 1'b1; // Unknown opcode
        endcase
        if (bad)
                e = DECODER_CTRL_ILLEGAL;
        return e;
endfunction

`endif

// ==== verification/tb_rv32i_decoder.sv ====
// Testbench for the RV32I decoder with seeded random instructions and a reference model
`timescale 1ns/1ps

module tb_rv32i_decoder import rv32i_decoder_pkg::*; ();

        localparam int RESET_CYCLES   = 16;
        localparam int NUM_VECTORS    = 3000;
        localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + 100;
        localparam logic [6:0] LEGAL_OPS [11] = '{OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH,
                OPCODE_LOAD, OPCODE_STORE, OPCODE_LUI, OPCODE_AUIPC, OPCODE_OPIMM, OPCODE_OP,
                OPCODE_FENCE, OPCODE_SYSTEM};

        logic          clk;
        logic          arst_n_i;        // Stimulus starts once this is released
        rv32_instr_t   instr_i;
        ctrl_fsm_t     ctrl_fsm_i;
        decoder_ctrl_t decoder_ctrl_o;
        decoder_ctrl_t expected;
        integer        seed;
        int            errors;
        int            checks;
        int            cycles;

        `include "decoder_ref_model.svh"

        rv32i_decoder rv32i_decoder_i (
                .instr_i        (instr_i),
                .ctrl_fsm_i     (ctrl_fsm_i),
                .decoder_ctrl_o (decoder_ctrl_o)
        );

        always #5 clk = ~clk; // 10 ns period

        // Reset low for the first cycles
        initial begin
                arst_n_i = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                arst_n_i <= 1'b1;
        end

        //////////////////////////////
        // Timeout and checking
        //////////////////////////////

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= TIMEOUT_CYCLES) begin
                        $display("Run timed out after %0d cycles", cycles);
                        $display("RESULT: FAIL");
                        $finish;
                end
        end

        task automatic check_value(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Fail %s: got %h expected %h (instr %h)", name, got, exp, instr_i);
                end
        endtask

        //////////////////////////////
        // Biased random instruction
        //////////////////////////////

        function automatic rv32_instr_t random_instr();
                rv32_instr_t ins;
                logic [31:0] sel;
                logic [3:0]  idx;
                ins = rv32_instr_t'($random(seed));
                sel = $random(seed);
                idx = 4'({$random(seed)} % 11);
                if ({$random(seed)} % 10 != 0)
                        ins.opcode = LEGAL_OPS[idx];                 // About 90% legal
                if (sel[4])
                        ins.funct7 = sel[5] ? FUNCT7_ALT : FUNCT7_ZERO;
                if (sel[6])
                        ins.rs1 = 5'd0;                              // CSR read-only forms
                if (sel[7])
                        ins.rd = 5'd0;
                if (ins.opcode == OPCODE_SYSTEM && sel[8]) begin
                        if (sel[9])
                                ins.funct3 = 3'd0;                   // Privileged group
                        case (sel[12:10])
                        3'd0:    {ins.funct7, ins.rs2} = SYS_ECALL;
                        3'd1:    {ins.funct7, ins.rs2} = SYS_EBREAK;
                        3'd2:    {ins.funct7, ins.rs2} = SYS_MRET;
                        3'd3:    {ins.funct7, ins.rs2} = SYS_DRET;
                        default: {ins.funct7, ins.rs2} = SYS_WFI;
                        endcase
                end
                return ins;
        endfunction

        initial begin
                seed       = 32'hfbc4;
                clk        = 1'b0;
                instr_i    = '0;
                ctrl_fsm_i = '0;
                cycles     = 0;
                errors     = 0;
                checks     = 0;
                wait (arst_n_i === 1'b1);
                repeat (NUM_VECTORS) begin
                        @(posedge clk);
                        instr_i    <= random_instr();
                        ctrl_fsm_i <= ctrl_fsm_t'(2'($random(seed)));
                        @(negedge clk);                              // Outputs settled
                        expected = expected_ctrl(instr_i, ctrl_fsm_i);
                        check_value("decoder_ctrl_o", 64'(decoder_ctrl_o), 64'(expected));
                        check_value("illegal_insn", 64'(decoder_ctrl_o.illegal_insn),
                                    64'(expected.illegal_insn));
                        check_value("alu_operator", 64'(decoder_ctrl_o.alu_operator),
                                    64'(expected.alu_operator));
                end
                $display("Errors: %0d of %0d checks over %0d vectors", errors, checks, NUM_VECTORS);
                if (errors == 0)
                        $display("RESULT: PASS");
                else
                        $display("RESULT: FAIL");
                $finish;
        end

endmodule
